/* filelist.f */
+incdir+include
source/soc_pkg.sv
source/reset_sequencer.sv
source/bus_decoder.sv
source/monitor_ram.sv
source/csr_bridge.sv
source/sysctl.sv
source/bus_meter.sv
source/soc_top.sv
tests/tb_clock_gen.sv
tests/tb_soc_top.sv

/* include/soc_cfg.svh */
// Reset lengths, monitor RAM size, CSR banks, address regions, GPIO widths and system ID
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Cycles of system reset after the last reset request
`define RST_HOLD_CYCLES 64
// Flash comes out of reset well before the rest of the system
`define FLASH_RST_CYCLES 16

// Monitor scratch RAM depth in 32-bit words
`define MONITOR_WORDS 256

// Address bits 30..28 of the monitor RAM, bit 31 ignored
`define REGION_MONITOR 3'b001
// Address bits 30..29 of the CSR space
`define REGION_CSR 2'b11

// CSR bank numbers, address bits 13..10 of the CSR word address
`define CSR_BANK_SYSCTL 1
`define CSR_BANK_METER 9

// GPIO widths
`define NGPIO_IN 7
`define NGPIO_OUT 2

`define SYSTEM_ID 32'h1004_4D31

`endif

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_soc_top \
	-f filelist.f -o tb_soc_top_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_soc_top_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0

/* source/bus_decoder.sv */
// Wishbone region decoder with strobe steering and return path multiplexer
`timescale 1ns/1ps
`include "soc_cfg.svh"

module bus_decoder (
	input logic sys_clk,
	input logic sys_rst_i,
	input soc_pkg::wb_adr_t wb_adr_i,
	input logic wb_stb_i,
	input logic wb_cyc_i,
	output soc_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack_o,
	output logic mon_stb_o,
	input soc_pkg::wb_dat_t mon_dat_i,
	input logic mon_ack_i,
	output logic csr_stb_o,
	input soc_pkg::wb_dat_t csr_dat_i,
	input logic csr_ack_i
);

	soc_pkg::bus_region_e region;
	logic access;

	// --------------------
	// Address decode
	// --------------------
	// Bit 31 is left out so shadow addresses alias
	always_comb begin
		if (wb_adr_i[30:28] == `REGION_MONITOR)
			region = soc_pkg::REGION_MON;
		else if (wb_adr_i[30:29] == `REGION_CSR)
			region = soc_pkg::REGION_CSR_SPACE;
		else
			region = soc_pkg::REGION_NONE;
	end

	// Strobe only counts inside a cycle
	assign access = wb_cyc_i & wb_stb_i;
	assign mon_stb_o = access & (region == soc_pkg::REGION_MON);
	assign csr_stb_o = access & (region == soc_pkg::REGION_CSR_SPACE);

	// --------------------
	// Return path
	// --------------------
	// Unmapped region never acks
	always_comb begin
		case (region)
			soc_pkg::REGION_MON: begin
				wb_dat_o = mon_dat_i;
				wb_ack_o = mon_ack_i;
			end
			soc_pkg::REGION_CSR_SPACE: begin
				wb_dat_o = csr_dat_i;
				wb_ack_o = csr_ack_i;
			end
			default: begin
				wb_dat_o = '0;
				wb_ack_o = 1'b0;
			end
		endcase
	end

	// Slaves only answer a strobe that is still held
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_ack_o |-> wb_stb_i);

endmodule

/* source/bus_meter.sv */
// Bus usage meter CSR bank counting monitor RAM strobe and ack cycles
`timescale 1ns/1ps
`include "soc_cfg.svh"

module bus_meter (
	input logic sys_clk,
	input logic sys_rst_i,
	input soc_pkg::csr_adr_t csr_a_i,
	input logic csr_we_i,
	input soc_pkg::wb_dat_t csr_di_i,
	output soc_pkg::wb_dat_t csr_do_o,
	input logic mon_stb_i,
	input logic mon_ack_i
);

	logic bank_sel;
	logic meter_en;
	logic [31:0] stb_count;
	logic [31:0] ack_count;

	assign bank_sel = (csr_a_i[13:10] == 4'(`CSR_BANK_METER));

	// Counters and control register
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			meter_en <= 1'b0;
			stb_count <= '0;
			ack_count <= '0;
		end else if (csr_we_i && bank_sel && csr_a_i[9:0] == soc_pkg::METER_CTRL) begin
			meter_en <= csr_di_i[0];
			// Bit 1 clears both counts
			if (csr_di_i[1]) begin
				stb_count <= '0;
				ack_count <= '0;
			end
		end else if (meter_en) begin
			stb_count <= stb_count + {31'd0, mon_stb_i};
			ack_count <= ack_count + {31'd0, mon_ack_i};
		end
	end

	// Registered read data, zero outside this bank
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i || !bank_sel)
			csr_do_o <= '0;
		else begin
			case (csr_a_i[9:0])
				soc_pkg::METER_CTRL: csr_do_o <= {31'd0, meter_en};
				soc_pkg::STB_COUNT: csr_do_o <= stb_count;
				soc_pkg::ACK_COUNT: csr_do_o <= ack_count;
				default: csr_do_o <= '0;
			endcase
		end
	end

endmodule

/* source/csr_bridge.sv */
// Wishbone to CSR bridge FSM with OR-combined CSR read data
`timescale 1ns/1ps

module csr_bridge (
	input logic sys_clk,
	input logic sys_rst_i,
	input soc_pkg::wb_adr_t wb_adr_i,
	input soc_pkg::wb_dat_t wb_dat_i,
	input logic wb_we_i,
	input logic wb_stb_i,
	output soc_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack_o,
	output soc_pkg::csr_adr_t csr_a_o,
	output logic csr_we_o,
	output soc_pkg::wb_dat_t csr_dw_o,
	input soc_pkg::wb_dat_t csr_sysctl_dr_i,
	input soc_pkg::wb_dat_t csr_meter_dr_i
);

	soc_pkg::csrbrg_state_e state;

	// --------------------
	// Access sequencing
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= soc_pkg::IDLE;
			csr_we_o <= 1'b0;
		end else begin
			case (state)
				soc_pkg::IDLE: begin
					if (wb_stb_i) begin
						// Write strobe goes out with the address
						csr_we_o <= wb_we_i;
						state <= soc_pkg::ACCESS;
					end
				end
				soc_pkg::ACCESS: begin
					// Slaves register their read data here
					csr_we_o <= 1'b0;
					state <= soc_pkg::LATCH;
				end
				soc_pkg::LATCH:
					state <= soc_pkg::ACK;
				default:
					state <= soc_pkg::IDLE;
			endcase
		end
	end

	// Word address and write data, held for the whole access
	always_ff @(posedge sys_clk) begin
		if (state == soc_pkg::IDLE && wb_stb_i) begin
			csr_a_o <= wb_adr_i[15:2];
			csr_dw_o <= wb_dat_i;
		end
		// Unselected banks return zero
		if (state == soc_pkg::LATCH)
			wb_dat_o <= csr_sysctl_dr_i | csr_meter_dr_i;
	end

	assign wb_ack_o = (state == soc_pkg::ACK);

	// Exactly one write cycle per access
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_we_o |=> !csr_we_o);

endmodule

/* source/monitor_ram.sv */
// Monitor scratch RAM with byte lane writes behind a Wishbone slave port
`timescale 1ns/1ps
`include "soc_cfg.svh"

module monitor_ram (
	input logic sys_clk,
	input logic sys_rst_i,
	input soc_pkg::wb_adr_t wb_adr_i,
	input soc_pkg::wb_dat_t wb_dat_i,
	input soc_pkg::wb_sel_t wb_sel_i,
	input logic wb_we_i,
	input logic wb_stb_i,
	output soc_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack_o
);

	soc_pkg::wb_dat_t mem [0:`MONITOR_WORDS-1];
	logic [7:0] word_idx;
	logic start;

	assign word_idx = wb_adr_i[9:2];
	// First cycle of the strobe, ack masks the second one
	assign start = wb_stb_i & ~wb_ack_o;

	// Storage and read port, contents survive reset
	always_ff @(posedge sys_clk) begin
		if (start) begin
			if (wb_we_i) begin
				for (int i = 0; i < 4; i++) begin
					if (wb_sel_i[i])
						mem[word_idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
				end
			end
			wb_dat_o <= mem[word_idx];
		end
	end

	// One ack per access
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= start;
	end

endmodule

/* source/reset_sequencer.sv */
// Reset sequencer with early flash reset release and long system reset hold
`timescale 1ns/1ps
`include "soc_cfg.svh"

module reset_sequencer (
	input logic sys_clk,
	input logic trigger_reset,
	input logic hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic request;
	logic [7:0] flash_cnt;
	logic [7:0] hold_cnt;

	// External reset or software hard reset
	assign request = trigger_reset | hard_reset_i;

	// Both counters reload on a request and run down to zero
	always_ff @(posedge sys_clk) begin
		if (request) begin
			flash_cnt <= 8'(`FLASH_RST_CYCLES);
			hold_cnt <= 8'(`RST_HOLD_CYCLES);
			flash_rst_n_o <= 1'b0;
			sys_rst_o <= 1'b1;
		end else begin
			if (flash_cnt != 8'd0)
				flash_cnt <= flash_cnt - 8'd1;
			if (hold_cnt != 8'd0)
				hold_cnt <= hold_cnt - 8'd1;
			// Outputs follow the count one edge later
			flash_rst_n_o <= (flash_cnt == 8'd0);
			sys_rst_o <= (hold_cnt != 8'd0);
		end
	end

	// Flash must be out of reset before the system starts
	assert property (@(posedge sys_clk) disable iff (trigger_reset)
		!sys_rst_o |-> flash_rst_n_o);

endmodule

/* source/soc_pkg.sv */
// Bus widths, CSR address type, bridge states, bus regions and CSR register indices
package soc_pkg;

	// Wishbone payload types
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0] wb_sel_t;

	// Bank in 13..10, register word index in 9..0
	typedef logic [13:0] csr_adr_t;

	typedef enum logic [1:0] {IDLE, ACCESS, LATCH, ACK} csrbrg_state_e;

	typedef enum logic [1:0] {REGION_NONE, REGION_MON, REGION_CSR_SPACE} bus_region_e;

	// System controller register map
	typedef enum logic [9:0] {
		GPIO_IN = 10'd0,
		GPIO_OUT = 10'd1,
		TIMER_CTRL = 10'd2,
		TIMER_COMPARE = 10'd3,
		TIMER_COUNT = 10'd4,
		SYSTEM_ID = 10'd5,
		HARD_RESET = 10'd6
	} sysctl_reg_e;

	// Bus meter register map
	typedef enum logic [9:0] {
		METER_CTRL = 10'd0,
		STB_COUNT = 10'd1,
		ACK_COUNT = 10'd2
	} meter_reg_e;

endpackage

/* source/soc_top.sv */
// SoC top level with reset, Wishbone decode, monitor RAM, CSR bridge and CSR peripherals
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_top (
	input logic sys_clk,
	input logic trigger_reset,
	input soc_pkg::wb_adr_t wb_adr_i,
	input soc_pkg::wb_dat_t wb_dat_i,
	input soc_pkg::wb_sel_t wb_sel_i,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output soc_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack_o,
	input logic [`NGPIO_IN-1:0] gpio_in_i,
	output logic [`NGPIO_OUT-1:0] led_o,
	output logic timer0_irq_o,
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	logic hard_reset;
	// Monitor RAM slave side
	logic mon_stb;
	logic mon_ack;
	soc_pkg::wb_dat_t mon_dat;
	// CSR bridge slave side
	logic csr_stb;
	logic csr_ack;
	soc_pkg::wb_dat_t csr_dat;
	// CSR bus
	soc_pkg::csr_adr_t csr_a;
	logic csr_we;
	soc_pkg::wb_dat_t csr_dw;
	soc_pkg::wb_dat_t csr_dr_sysctl;
	soc_pkg::wb_dat_t csr_dr_meter;

	// --------------------
	// Reset and decode
	// --------------------
	reset_sequencer i_reset_sequencer (.sys_clk(sys_clk), .trigger_reset(trigger_reset),
		.hard_reset_i(hard_reset), .sys_rst_o(sys_rst), .flash_rst_n_o(flash_rst_n_o));

	assign periph_rst_n_o = ~sys_rst;

	bus_decoder i_bus_decoder (.sys_clk(sys_clk), .sys_rst_i(sys_rst), .wb_adr_i(wb_adr_i),
		.wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.mon_stb_o(mon_stb), .mon_dat_i(mon_dat), .mon_ack_i(mon_ack),
		.csr_stb_o(csr_stb), .csr_dat_i(csr_dat), .csr_ack_i(csr_ack));

	// --------------------
	// Wishbone slaves
	// --------------------
	monitor_ram i_monitor_ram (.sys_clk(sys_clk), .sys_rst_i(sys_rst), .wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i), .wb_stb_i(mon_stb),
		.wb_dat_o(mon_dat), .wb_ack_o(mon_ack));

	csr_bridge i_csr_bridge (.sys_clk(sys_clk), .sys_rst_i(sys_rst), .wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i), .wb_stb_i(csr_stb), .wb_dat_o(csr_dat),
		.wb_ack_o(csr_ack), .csr_a_o(csr_a), .csr_we_o(csr_we), .csr_dw_o(csr_dw),
		.csr_sysctl_dr_i(csr_dr_sysctl), .csr_meter_dr_i(csr_dr_meter));

	// --------------------
	// CSR peripherals
	// --------------------
	sysctl i_sysctl (.sys_clk(sys_clk), .sys_rst_i(sys_rst), .csr_a_i(csr_a),
		.csr_we_i(csr_we), .csr_di_i(csr_dw), .csr_do_o(csr_dr_sysctl),
		.gpio_in_i(gpio_in_i), .gpio_out_o(led_o), .timer0_irq_o(timer0_irq_o),
		.hard_reset_o(hard_reset));

	// Meter watches the monitor RAM handshake
	bus_meter i_bus_meter (.sys_clk(sys_clk), .sys_rst_i(sys_rst), .csr_a_i(csr_a),
		.csr_we_i(csr_we), .csr_di_i(csr_dw), .csr_do_o(csr_dr_meter),
		.mon_stb_i(mon_stb), .mon_ack_i(mon_ack));

endmodule

/* source/sysctl.sv */
// System controller CSR bank with GPIO, timer, system ID and hard reset request
`timescale 1ns/1ps
`include "soc_cfg.svh"

module sysctl (
	input logic sys_clk,
	input logic sys_rst_i,
	input soc_pkg::csr_adr_t csr_a_i,
	input logic csr_we_i,
	input soc_pkg::wb_dat_t csr_di_i,
	output soc_pkg::wb_dat_t csr_do_o,
	input logic [`NGPIO_IN-1:0] gpio_in_i,
	output logic [`NGPIO_OUT-1:0] gpio_out_o,
	output logic timer0_irq_o,
	output logic hard_reset_o
);

	logic [`NGPIO_IN-1:0] gpio_meta;
	logic [`NGPIO_IN-1:0] gpio_sync;
	logic bank_sel;
	logic timer_en;
	logic timer_ar;
	logic [31:0] timer_compare;
	logic [31:0] timer_count;

	assign bank_sel = (csr_a_i[13:10] == 4'(`CSR_BANK_SYSCTL));

	// Two-flop synchronizer for the inputs
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_in_i;
		gpio_sync <= gpio_meta;
	end

	// --------------------
	// Timer and writes
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			timer_en <= 1'b0;
			timer_ar <= 1'b0;
			timer_compare <= 32'hffff_ffff;
			timer_count <= '0;
			timer0_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			// Single cycle pulses
			timer0_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
			if (timer_en) begin
				if (timer_count == timer_compare) begin
					timer0_irq_o <= 1'b1;
					timer_count <= '0;
					// One-shot stops here
					if (!timer_ar)
						timer_en <= 1'b0;
				end else
					timer_count <= timer_count + 32'd1;
			end
			// CSR writes take priority over the timer
			if (csr_we_i && bank_sel) begin
				case (csr_a_i[9:0])
					soc_pkg::GPIO_OUT: gpio_out_o <= csr_di_i[`NGPIO_OUT-1:0];
					soc_pkg::TIMER_CTRL: begin
						timer_en <= csr_di_i[0];
						timer_ar <= csr_di_i[1];
					end
					soc_pkg::TIMER_COMPARE: timer_compare <= csr_di_i;
					soc_pkg::TIMER_COUNT: timer_count <= csr_di_i;
					soc_pkg::HARD_RESET: hard_reset_o <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// --------------------
	// Read data
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i || !bank_sel)
			csr_do_o <= '0;
		else begin
			case (csr_a_i[9:0])
				soc_pkg::GPIO_IN: csr_do_o <= {{(32-`NGPIO_IN){1'b0}}, gpio_sync};
				soc_pkg::GPIO_OUT: csr_do_o <= {{(32-`NGPIO_OUT){1'b0}}, gpio_out_o};
				soc_pkg::TIMER_CTRL: csr_do_o <= {30'd0, timer_ar, timer_en};
				soc_pkg::TIMER_COMPARE: csr_do_o <= timer_compare;
				soc_pkg::TIMER_COUNT: csr_do_o <= timer_count;
				soc_pkg::SYSTEM_ID: csr_do_o <= `SYSTEM_ID;
				default: csr_do_o <= '0;
			endcase
		end
	end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps

module tb_clock_gen (
	output logic sys_clk,
	output logic trigger_reset
);

	// 8 ns period
	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// Reset held for 8 rising edges, released on a falling edge
	initial begin
		trigger_reset = 1'b1;
		repeat (8) @(posedge sys_clk);
		@(negedge sys_clk);
		trigger_reset = 1'b0;
	end

endmodule

/* tests/tb_soc_top.sv */
// Testbench for soc_top with a stimulus table, bus master, checker and timeout
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_top;

	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_WAIT_IRQ, OP_RESET} op_e;

	// Write rows expect led_o, read rows expect wb_dat_o, wait rows expect a pulse count
	typedef struct packed {
		op_e op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0] sel;
		logic [31:0] exp;
	} row_t;

	localparam logic [31:0] SEED = 32'h977b_3cbf;
	localparam int TIMER_CMP = 40;
	localparam int METER_ACCESSES = 3;
	// Monitor word used by all RAM rows, plain and bit 31 shadow
	localparam logic [31:0] MON_WORD = {1'b0, `REGION_MONITOR, 28'h000_0010};
	localparam logic [31:0] MON_SHADOW = MON_WORD | 32'h8000_0000;

	logic sys_clk;
	logic trigger_reset;
	soc_pkg::wb_adr_t wb_adr;
	soc_pkg::wb_dat_t wb_dat;
	soc_pkg::wb_sel_t wb_sel;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	soc_pkg::wb_dat_t wb_rdata;
	logic wb_ack;
	logic [`NGPIO_IN-1:0] gpio_in;
	logic [`NGPIO_OUT-1:0] led;
	logic timer0_irq;
	logic flash_rst_n;
	logic periph_rst_n;

	row_t table_q[$];
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int timeout_limit = 0;

	tb_clock_gen i_tb_clock_gen (.sys_clk(sys_clk), .trigger_reset(trigger_reset));

	soc_top i_soc_top (.sys_clk(sys_clk), .trigger_reset(trigger_reset), .wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat), .wb_sel_i(wb_sel), .wb_we_i(wb_we), .wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb), .wb_dat_o(wb_rdata), .wb_ack_o(wb_ack), .gpio_in_i(gpio_in),
		.led_o(led), .timer0_irq_o(timer0_irq), .flash_rst_n_o(flash_rst_n),
		.periph_rst_n_o(periph_rst_n));

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] csr_addr(input int bank, input int index);
		// Bank at byte address bits 15..12, register word index at 11..2
		return {1'b0, `REGION_CSR, 29'd0} | (32'(bank) << 12) | (32'(index) << 2);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		end
	endtask

	task automatic add_row(input op_e op, input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input logic [31:0] exp);
		table_q.push_back({op, adr, dat, sel, exp});
	endtask

	// One Wishbone access, stb held through the cycle that carries ack
	task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input logic we, output logic [31:0] rdata, output int latency);
		@(negedge sys_clk);
		wb_adr = adr;
		wb_dat = dat;
		wb_sel = sel;
		wb_we = we;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		latency = 1;
		@(negedge sys_clk);
		while (!wb_ack) begin
			@(negedge sys_clk);
			latency++;
		end
		rdata = wb_rdata;
		@(negedge sys_clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// Release cycles counted from the first edge without a reset request
	task automatic check_reset_release();
		int edges;
		int flash_edge;
		int periph_edge;
		edges = 0;
		flash_edge = 0;
		periph_edge = 0;
		repeat (4) @(negedge sys_clk);
		check_value("wb_ack_o in reset", 32'(wb_ack), 32'd0);
		check_value("led_o in reset", 32'(led), 32'd0);
		check_value("timer0_irq_o in reset", 32'(timer0_irq), 32'd0);
		check_value("flash_rst_n_o in reset", 32'(flash_rst_n), 32'd0);
		check_value("periph_rst_n_o in reset", 32'(periph_rst_n), 32'd0);
		@(negedge trigger_reset);
		while (periph_edge == 0) begin
			@(posedge sys_clk);
			edges++;
			@(negedge sys_clk);
			if (flash_edge == 0 && flash_rst_n)
				flash_edge = edges;
			if (periph_rst_n)
				periph_edge = edges;
		end
		check_value("flash_rst_n_o release cycle", 32'(flash_edge - 1), `FLASH_RST_CYCLES);
		check_value("periph_rst_n_o release cycle", 32'(periph_edge - 1), `RST_HOLD_CYCLES);
	endtask

	task automatic apply_row(input row_t row);
		logic [31:0] rdata;
		int latency;
		int pulses;
		logic csr_hit;
		csr_hit = (row.adr[30:29] == `REGION_CSR);
		case (row.op)
			OP_READ: begin
				bus_access(row.adr, row.dat, row.sel, 1'b0, rdata, latency);
				check_value($sformatf("wb_dat_o at 0x%08h", row.adr), rdata, row.exp);
			end
			OP_WRITE, OP_RESET: begin
				bus_access(row.adr, row.dat, row.sel, 1'b1, rdata, latency);
				if (row.op == OP_RESET) begin
					check_value("periph_rst_n_o after hard reset", 32'(periph_rst_n), 32'd0);
					// Timeout covers a hold that never ends
					while (!periph_rst_n)
						@(negedge sys_clk);
				end
				check_value($sformatf("led_o after 0x%08h", row.adr), 32'(led), row.exp);
			end
			default: begin
				// Count irq pulses over a window of dat cycles
				pulses = 0;
				repeat (row.dat) begin
					@(negedge sys_clk);
					if (timer0_irq)
						pulses++;
				end
				check_value("timer0_irq_o pulses", 32'(pulses), row.exp);
			end
		endcase
		if (row.op != OP_WAIT_IRQ)
			check_value($sformatf("ack latency at 0x%08h", row.adr), 32'(latency),
				csr_hit ? 32'd3 : 32'd1);
	endtask

	task automatic build_table();
		int sys_bank;
		int met_bank;
		sys_bank = `CSR_BANK_SYSCTL;
		met_bank = `CSR_BANK_METER;
		// Byte lane merge, 11223344 then lanes 0 and 2 then lane 1
		add_row(OP_WRITE, MON_WORD, 32'h1122_3344, 4'hf, 32'd0);
		add_row(OP_WRITE, MON_WORD, 32'haabb_ccdd, 4'h5, 32'd0);
		add_row(OP_WRITE, MON_WORD, 32'h0000_ee00, 4'h2, 32'd0);
		add_row(OP_READ, MON_SHADOW, 32'd0, 4'hf, 32'h11bb_eedd);
		add_row(OP_READ, csr_addr(sys_bank, int'(soc_pkg::SYSTEM_ID)), 0, 4'hf, `SYSTEM_ID);
		add_row(OP_READ, csr_addr(sys_bank, int'(soc_pkg::GPIO_IN)), 0, 4'hf, 32'(gpio_in));
		// One-shot timer
		add_row(OP_WRITE, csr_addr(sys_bank, int'(soc_pkg::TIMER_COMPARE)), TIMER_CMP, 4'hf, 0);
		add_row(OP_WRITE, csr_addr(sys_bank, int'(soc_pkg::TIMER_CTRL)), 32'd1, 4'hf, 0);
		add_row(OP_WAIT_IRQ, 32'd0, TIMER_CMP + 5, 4'h0, 32'd1);
		add_row(OP_READ, csr_addr(sys_bank, int'(soc_pkg::TIMER_CTRL)), 0, 4'hf, 32'd0);
		// Meter, clear and enable together
		add_row(OP_WRITE, csr_addr(met_bank, int'(soc_pkg::METER_CTRL)), 32'd3, 4'hf, 0);
		for (int i = 0; i < METER_ACCESSES; i++)
			add_row(OP_READ, MON_WORD, 32'd0, 4'hf, 32'h11bb_eedd);
		add_row(OP_WRITE, csr_addr(met_bank, int'(soc_pkg::METER_CTRL)), 32'd0, 4'hf, 0);
		add_row(OP_READ, csr_addr(met_bank, int'(soc_pkg::ACK_COUNT)), 0, 4'hf, METER_ACCESSES);
		add_row(OP_READ, csr_addr(met_bank, int'(soc_pkg::STB_COUNT)), 0, 4'hf,
			2 * METER_ACCESSES);
		// LEDs, then hard reset clears them but not the RAM
		add_row(OP_WRITE, csr_addr(sys_bank, int'(soc_pkg::GPIO_OUT)), 32'd3, 4'hf, 32'd3);
		add_row(OP_READ, csr_addr(sys_bank, int'(soc_pkg::GPIO_OUT)), 0, 4'hf, 32'd3);
		add_row(OP_RESET, csr_addr(sys_bank, int'(soc_pkg::HARD_RESET)), 32'd1, 4'hf, 0);
		add_row(OP_READ, MON_SHADOW, 32'd0, 4'hf, 32'h11bb_eedd);
		add_row(OP_READ, csr_addr(sys_bank, int'(soc_pkg::GPIO_OUT)), 0, 4'hf, 32'd0);
		add_row(OP_READ, csr_addr(met_bank, int'(soc_pkg::STB_COUNT)), 0, 4'hf, 32'd0);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		logic [31:0] rand_word;
		wb_adr = '0;
		wb_dat = '0;
		wb_sel = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		void'($urandom(SEED));
		rand_word = $urandom();
		gpio_in = rand_word[`NGPIO_IN-1:0];
		build_table();
		timeout_limit = table_q.size() * 10 + 2 * `RST_HOLD_CYCLES + TIMER_CMP + 100;
		check_reset_release();
		foreach (table_q[i])
			apply_row(table_q[i]);
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Run length guard
	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_limit);
			$display("Checks: %0d  errors: %0d", checks, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule
